//--- board_pkg.sv
// board code enum, code and scroll offset widths, vertical scroll constant, map row lookup
package board_pkg;

    localparam int pcb_width      = 8;   // raw board code port
    localparam int scroll_y_width = 16;
    localparam int map_row_width  = 2;   // selects one of the address map rows

    localparam logic [scroll_y_width-1:0] scroll_y_shift_boards = 16;   // zero wing, hellfire

    // values follow the raw board code
    typedef enum logic [3:0] {
        board_zero_wing     = 4'd0,
        board_out_zone_conv = 4'd1,
        board_out_zone      = 4'd2,
        board_hellfire      = 4'd3,
        board_truxton       = 4'd4,
        board_unsupported   = 4'd15
    } board_t;

    // converted out zone runs on the zero wing map
    function automatic logic [map_row_width-1:0] map_row(board_t b);
        logic [map_row_width-1:0] row;
        case (b)
            board_out_zone: row = 2'd1;
            board_hellfire: row = 2'd2;
            board_truxton:  row = 2'd3;
            default:        row = 2'd0;   // zero wing and conversion
        endcase
        return row;
    endfunction

endpackage

//--- map_pkg.sv
// 68000 region and Z80 port enums, address widths, per-map base, span and presence tables
package map_pkg;

    localparam int n_m68k_regions  = 21;
    localparam int n_z80_ports     = 8;
    localparam int m68k_addr_width = 24;
    localparam int z80_addr_width  = 16;
    localparam int n_map_rows      = 4;   // zero wing, out zone, hellfire, truxton

    typedef enum logic [4:0] {
        rgn_prog_rom, rgn_ram, rgn_scroll_ofs_x, rgn_scroll_ofs_y,
        rgn_frame_done, rgn_int_en, rgn_crtc, rgn_tile_ofs,
        rgn_tile_attr, rgn_tile_num, rgn_scroll, rgn_shared_ram,
        rgn_vblank, rgn_tile_palette, rgn_bcu_flip, rgn_sprite_palette,
        rgn_sprite_ofs, rgn_sprite, rgn_sprite_size, rgn_fcu_flip,
        rgn_reset_z80
    } m68k_region_t;

    typedef enum logic [2:0] {
        port_p1, port_p2, port_dswa, port_dswb,
        port_system, port_tjump, port_sound0, port_sound1
    } z80_port_t;

    // columns in m68k_region_t order
    localparam logic [m68k_addr_width-1:0] m68k_base [n_map_rows][n_m68k_regions] = '{
        '{24'h000000, 24'h080000, 24'h0c0000, 24'h0c0002, 24'h4c0000, 24'h400002,
          24'h400008, 24'h480002, 24'h480004, 24'h480006, 24'h480010, 24'h440000,
          24'h400000, 24'h404000, 24'h480000, 24'h406000, 24'h4c0002, 24'h4c0004,
          24'h4c0006, 24'h0c0006, 24'h000000},   // zero wing
        '{24'h000000, 24'h240000, 24'h340000, 24'h340002, 24'h100000, 24'h300002,
          24'h300008, 24'h200002, 24'h200004, 24'h200006, 24'h200010, 24'h140000,
          24'h300000, 24'h304000, 24'h200000, 24'h306000, 24'h100002, 24'h100004,
          24'h100006, 24'h340006, 24'h000000},   // out zone
        '{24'h000000, 24'h040000, 24'h180000, 24'h180002, 24'h140000, 24'h080002,
          24'h080008, 24'h100002, 24'h100004, 24'h100006, 24'h100010, 24'h0c0000,
          24'h080000, 24'h084000, 24'h100000, 24'h086000, 24'h140002, 24'h140004,
          24'h140006, 24'h180006, 24'h180008},   // hellfire
        '{24'h000000, 24'h080000, 24'h1c0000, 24'h1c0002, 24'h0c0000, 24'h140002,
          24'h140008, 24'h100002, 24'h100004, 24'h100006, 24'h100010, 24'h180000,
          24'h140000, 24'h144000, 24'h100000, 24'h146000, 24'h0c0002, 24'h0c0004,
          24'h0c0006, 24'h1c0006, 24'h1d0000}    // truxton
    };

    // ignored low address bits per region
    localparam logic [7:0] m68k_span [n_map_rows][n_m68k_regions] = '{
        '{8'd19, 8'd15, 8'd1, 8'd1, 8'd1, 8'd1, 8'd3, 8'd1, 8'd1, 8'd1, 8'd4,
          8'd12, 8'd1, 8'd11, 8'd1, 8'd11, 8'd1, 8'd1, 8'd1, 8'd1, 8'd0},
        '{8'd18, 8'd14, 8'd1, 8'd1, 8'd1, 8'd1, 8'd3, 8'd1, 8'd1, 8'd1, 8'd4,
          8'd12, 8'd1, 8'd11, 8'd1, 8'd11, 8'd1, 8'd1, 8'd1, 8'd1, 8'd0},
        '{8'd18, 8'd15, 8'd1, 8'd1, 8'd1, 8'd1, 8'd3, 8'd1, 8'd1, 8'd1, 8'd4,
          8'd12, 8'd1, 8'd11, 8'd1, 8'd11, 8'd1, 8'd1, 8'd1, 8'd1, 8'd1},
        '{8'd18, 8'd14, 8'd1, 8'd1, 8'd1, 8'd1, 8'd3, 8'd1, 8'd1, 8'd1, 8'd4,
          8'd12, 8'd1, 8'd11, 8'd1, 8'd11, 8'd1, 8'd1, 8'd1, 8'd1, 8'd1}
    };

    // bit index is the region, only hellfire and truxton have a z80 reset
    localparam logic [n_m68k_regions-1:0] m68k_present [n_map_rows] = '{
        21'h0fffff, 21'h0fffff, 21'h1fffff, 21'h1fffff
    };

    // columns in z80_port_t order
    localparam logic [7:0] z80_port_addr [n_map_rows][n_z80_ports] = '{
        '{8'h00, 8'h08, 8'h20, 8'h28, 8'h80, 8'h88, 8'ha8, 8'ha9},   // zero wing
        '{8'h14, 8'h18, 8'h08, 8'h0c, 8'h10, 8'h1c, 8'h00, 8'h01},   // out zone
        '{8'h40, 8'h50, 8'h00, 8'h10, 8'h60, 8'h20, 8'h70, 8'h71},   // hellfire
        '{8'h00, 8'h10, 8'h40, 8'h50, 8'h20, 8'h70, 8'h60, 8'h61}    // truxton
    };

    localparam logic [n_z80_ports-1:0] z80_present [n_map_rows] = '{
        8'hff, 8'hff, 8'hff, 8'hff
    };

endpackage

//--- board_config.sv
// board code latch with validity and vertical scroll offset derivation
module board_config
    import board_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [pcb_width-1:0]      pcb,
    input  logic                      cfg_strobe,
    output board_t                    board,
    output logic                      board_valid,
    output logic [scroll_y_width-1:0] scroll_y_offset
);

    board_t board_next;

    always_comb begin
        case (pcb)
            8'd0:    board_next = board_zero_wing;
            8'd1:    board_next = board_out_zone_conv;   // shares the zero wing map
            8'd2:    board_next = board_out_zone;
            8'd3:    board_next = board_hellfire;
            8'd4:    board_next = board_truxton;
            default: board_next = board_unsupported;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            board <= board_unsupported;
        end else if (cfg_strobe) begin
            board <= board_next;   // held until the next strobe
        end
    end

    assign board_valid = (board != board_unsupported);

    always_comb begin
        if (board == board_zero_wing || board == board_hellfire) begin
            scroll_y_offset = scroll_y_shift_boards;
        end else begin
            scroll_y_offset = '0;   // conversion board keeps no shift
        end
    end

endmodule

//--- m68k_decoder.sv
// 68000 address decoder against the active board's region table
module m68k_decoder
    import board_pkg::*;
    import map_pkg::*;
(
    input  logic [m68k_addr_width-1:0] cpu_a,
    input  logic                       cpu_as_n,
    input  board_t                     board,
    output logic [n_m68k_regions-1:0]  m68k_hit
);

    logic [map_row_width-1:0] row;

    assign row = map_row(board);

    always_comb begin
        for (int r = 0; r < n_m68k_regions; r++) begin
            m68k_hit[r] = m68k_present[row][r] && !cpu_as_n &&
                          ((cpu_a >> m68k_span[row][r]) ==
                           (m68k_base[row][r] >> m68k_span[row][r]));   // compare above span
        end
    end

endmodule

//--- z80_decoder.sv
// Z80 I/O port decoder against the active board's port table
module z80_decoder
    import board_pkg::*;
    import map_pkg::*;
(
    input  logic [z80_addr_width-1:0] z80_addr,
    input  logic                      iorq_n,
    input  board_t                    board,
    output logic [n_z80_ports-1:0]    z80_hit
);

    logic [map_row_width-1:0] row;

    assign row = map_row(board);

    // only the low byte selects an I/O port
    always_comb begin
        for (int p = 0; p < n_z80_ports; p++) begin
            z80_hit[p] = z80_present[row][p] && !iorq_n &&
                         (z80_addr[7:0] == z80_port_addr[row][p]);
        end
    end

endmodule

//--- cs_register.sv
// output register stage for 68000 and Z80 selects with board gating and select checks
module cs_register
    import map_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      board_valid,
    input  logic [n_m68k_regions-1:0] m68k_hit,
    input  logic [n_z80_ports-1:0]    z80_hit,
    output logic [n_m68k_regions-1:0] m68k_cs,
    output logic [n_z80_ports-1:0]    z80_cs
);

    logic [n_m68k_regions-1:0] m68k_gated;
    logic [n_z80_ports-1:0]    z80_gated;

    assign m68k_gated = m68k_hit & {n_m68k_regions{board_valid}};
    assign z80_gated  = z80_hit & {n_z80_ports{board_valid}};

    always_ff @(posedge clk) begin
        if (rst) begin
            m68k_cs <= '0;
            z80_cs  <= '0;
        end else begin
            m68k_cs <= m68k_gated;   // one cycle after the address sample
            z80_cs  <= z80_gated;
        end
    end

    // regions of one map must never overlap
    m68k_cs_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(m68k_cs)
    ) else $error("cs_register: several 68000 selects high %h", m68k_cs);

    z80_cs_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(z80_cs)
    ) else $error("cs_register: several Z80 selects high %h", z80_cs);

endmodule

//--- toaplan_chip_select.sv
// chip select top level joining board config, both decoders and the select register
module toaplan_chip_select
    import board_pkg::*;
    import map_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [pcb_width-1:0]       pcb,
    input  logic                       cfg_strobe,
    input  logic [m68k_addr_width-1:0] cpu_a,
    input  logic                       cpu_as_n,
    input  logic [z80_addr_width-1:0]  z80_addr,
    input  logic                       iorq_n,

    output logic prog_rom_cs,
    output logic ram_cs,
    output logic scroll_ofs_x_cs,
    output logic scroll_ofs_y_cs,
    output logic frame_done_cs,
    output logic int_en_cs,
    output logic crtc_cs,
    output logic tile_ofs_cs,
    output logic tile_attr_cs,
    output logic tile_num_cs,
    output logic scroll_cs,
    output logic shared_ram_cs,
    output logic vblank_cs,
    output logic tile_palette_cs,
    output logic bcu_flip_cs,
    output logic sprite_palette_cs,
    output logic sprite_ofs_cs,
    output logic sprite_cs,
    output logic sprite_size_cs,
    output logic fcu_flip_cs,
    output logic reset_z80_cs,

    output logic z80_p1_cs,
    output logic z80_p2_cs,
    output logic z80_dswa_cs,
    output logic z80_dswb_cs,
    output logic z80_system_cs,
    output logic z80_tjump_cs,
    output logic z80_sound0_cs,
    output logic z80_sound1_cs,

    output logic [scroll_y_width-1:0] scroll_y_offset
);

    board_t                    board;
    logic                      board_valid;
    logic [n_m68k_regions-1:0] m68k_hit;
    logic [n_z80_ports-1:0]    z80_hit;
    logic [n_m68k_regions-1:0] m68k_cs;
    logic [n_z80_ports-1:0]    z80_cs;

    board_config board_config_inst (
        .clk             (clk),
        .rst             (rst),
        .pcb             (pcb),
        .cfg_strobe      (cfg_strobe),
        .board           (board),
        .board_valid     (board_valid),
        .scroll_y_offset (scroll_y_offset)
    );

    m68k_decoder m68k_decoder_inst (
        .cpu_a    (cpu_a),
        .cpu_as_n (cpu_as_n),
        .board    (board),
        .m68k_hit (m68k_hit)
    );

    z80_decoder z80_decoder_inst (
        .z80_addr (z80_addr),
        .iorq_n   (iorq_n),
        .board    (board),
        .z80_hit  (z80_hit)
    );

    cs_register cs_register_inst (
        .clk         (clk),
        .rst         (rst),
        .board_valid (board_valid),
        .m68k_hit    (m68k_hit),
        .z80_hit     (z80_hit),
        .m68k_cs     (m68k_cs),
        .z80_cs      (z80_cs)
    );

    // registered vectors out to the board-facing pins
    assign prog_rom_cs       = m68k_cs[rgn_prog_rom];
    assign ram_cs            = m68k_cs[rgn_ram];
    assign scroll_ofs_x_cs   = m68k_cs[rgn_scroll_ofs_x];
    assign scroll_ofs_y_cs   = m68k_cs[rgn_scroll_ofs_y];
    assign frame_done_cs     = m68k_cs[rgn_frame_done];
    assign int_en_cs         = m68k_cs[rgn_int_en];
    assign crtc_cs           = m68k_cs[rgn_crtc];
    assign tile_ofs_cs       = m68k_cs[rgn_tile_ofs];
    assign tile_attr_cs      = m68k_cs[rgn_tile_attr];
    assign tile_num_cs       = m68k_cs[rgn_tile_num];
    assign scroll_cs         = m68k_cs[rgn_scroll];
    assign shared_ram_cs     = m68k_cs[rgn_shared_ram];
    assign vblank_cs         = m68k_cs[rgn_vblank];
    assign tile_palette_cs   = m68k_cs[rgn_tile_palette];
    assign bcu_flip_cs       = m68k_cs[rgn_bcu_flip];
    assign sprite_palette_cs = m68k_cs[rgn_sprite_palette];
    assign sprite_ofs_cs     = m68k_cs[rgn_sprite_ofs];
    assign sprite_cs         = m68k_cs[rgn_sprite];
    assign sprite_size_cs    = m68k_cs[rgn_sprite_size];
    assign fcu_flip_cs       = m68k_cs[rgn_fcu_flip];
    assign reset_z80_cs      = m68k_cs[rgn_reset_z80];

    assign z80_p1_cs     = z80_cs[port_p1];
    assign z80_p2_cs     = z80_cs[port_p2];
    assign z80_dswa_cs   = z80_cs[port_dswa];
    assign z80_dswb_cs   = z80_cs[port_dswb];
    assign z80_system_cs = z80_cs[port_system];
    assign z80_tjump_cs  = z80_cs[port_tjump];
    assign z80_sound0_cs = z80_cs[port_sound0];
    assign z80_sound1_cs = z80_cs[port_sound1];

endmodule

//--- tb_chip_select.sv
// testbench for the chip select top level with stimulus table, compare tasks and timeout
module tb_chip_select
    import board_pkg::*;
    import map_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                       cfg;        // pulse the configuration strobe first
        logic [pcb_width-1:0]       code;
        logic                       is_z80;
        logic [m68k_addr_width-1:0] addr;
        logic                       strobe_n;
        logic                       exp_hit;
        m68k_region_t               exp_rgn;
        z80_port_t                  exp_port;
        logic [scroll_y_width-1:0]  exp_scroll;
    } entry_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [pcb_width-1:0] pcb = '0;
    logic cfg_strobe = 1'b0;
    logic [m68k_addr_width-1:0] cpu_a = '0;
    logic cpu_as_n = 1'b1;
    logic [z80_addr_width-1:0] z80_addr = '0;
    logic iorq_n = 1'b1;
    logic [n_m68k_regions-1:0] m68k_seen;
    logic [n_z80_ports-1:0] z80_seen;
    logic [scroll_y_width-1:0] scroll_y_offset;

    entry_t table_q[$];
    logic [31:0] rng = 32'hf3a4_16d8;
    int cycles = 0;
    int cycle_limit = 0;
    int fails = 0;

    always #10 clk = ~clk;   // 20 ns period

    toaplan_chip_select toaplan_chip_select_inst (
        .clk(clk), .rst(rst), .pcb(pcb), .cfg_strobe(cfg_strobe),
        .cpu_a(cpu_a), .cpu_as_n(cpu_as_n), .z80_addr(z80_addr), .iorq_n(iorq_n),
        .prog_rom_cs(m68k_seen[0]), .ram_cs(m68k_seen[1]),
        .scroll_ofs_x_cs(m68k_seen[2]), .scroll_ofs_y_cs(m68k_seen[3]),
        .frame_done_cs(m68k_seen[4]), .int_en_cs(m68k_seen[5]), .crtc_cs(m68k_seen[6]),
        .tile_ofs_cs(m68k_seen[7]), .tile_attr_cs(m68k_seen[8]),
        .tile_num_cs(m68k_seen[9]), .scroll_cs(m68k_seen[10]),
        .shared_ram_cs(m68k_seen[11]), .vblank_cs(m68k_seen[12]),
        .tile_palette_cs(m68k_seen[13]), .bcu_flip_cs(m68k_seen[14]),
        .sprite_palette_cs(m68k_seen[15]), .sprite_ofs_cs(m68k_seen[16]),
        .sprite_cs(m68k_seen[17]), .sprite_size_cs(m68k_seen[18]),
        .fcu_flip_cs(m68k_seen[19]), .reset_z80_cs(m68k_seen[20]),
        .z80_p1_cs(z80_seen[0]), .z80_p2_cs(z80_seen[1]), .z80_dswa_cs(z80_seen[2]),
        .z80_dswb_cs(z80_seen[3]), .z80_system_cs(z80_seen[4]),
        .z80_tjump_cs(z80_seen[5]), .z80_sound0_cs(z80_seen[6]),
        .z80_sound1_cs(z80_seen[7]), .scroll_y_offset(scroll_y_offset)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // codes 0 and 1 share the zero wing map
    function automatic int row_for_code(logic [pcb_width-1:0] code);
        if (code <= 8'd1) return 0;
        return int'(code) - 1;
    endfunction

    function automatic logic [scroll_y_width-1:0] scroll_for_code(logic [pcb_width-1:0] code);
        if (code == 8'd0 || code == 8'd3) return scroll_y_shift_boards;
        return '0;
    endfunction

    task automatic add_entry(input logic cfg, input logic [pcb_width-1:0] code,
                             input logic is_z80, input logic [m68k_addr_width-1:0] addr,
                             input logic strobe_n, input logic exp_hit,
                             input m68k_region_t rgn, input z80_port_t port);
        entry_t e;
        e.cfg = cfg;
        e.code = code;
        e.is_z80 = is_z80;
        e.addr = addr;
        e.strobe_n = strobe_n;
        e.exp_hit = exp_hit;
        e.exp_rgn = rgn;
        e.exp_port = port;
        e.exp_scroll = cfg ? scroll_for_code(code) : '0;   // zero until first strobe
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [pcb_width-1:0] codes [5];
        logic [m68k_addr_width-1:0] base;
        logic [m68k_addr_width-1:0] mask;
        int row;
        codes = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4};
        add_entry(1'b0, 8'd0, 1'b0, 24'h000000, 1'b0, 1'b0, rgn_prog_rom, port_p1);
        add_entry(1'b0, 8'd0, 1'b0, 24'h080000, 1'b0, 1'b0, rgn_prog_rom, port_p1);
        add_entry(1'b0, 8'd0, 1'b1, 24'h000000, 1'b0, 1'b0, rgn_prog_rom, port_p1);
        foreach (codes[c]) begin
            row = row_for_code(codes[c]);
            for (int r = 0; r < n_m68k_regions; r++) begin
                if (m68k_present[row][r]) begin
                    base = m68k_base[row][r];
                    mask = (24'h1 << m68k_span[row][r]) - 24'h1;
                    rng = xorshift32(rng);
                    add_entry(1'b1, codes[c], 1'b0, base, 1'b0, 1'b1,
                              m68k_region_t'(r), port_p1);
                    add_entry(1'b1, codes[c], 1'b0, (base & ~mask) | (rng[23:0] & mask),
                              1'b0, 1'b1, m68k_region_t'(r), port_p1);
                end
            end
            for (int p = 0; p < n_z80_ports; p++) begin
                if (z80_present[row][p]) begin
                    rng = xorshift32(rng);   // upper byte must not matter
                    add_entry(1'b1, codes[c], 1'b1, {8'h00, rng[7:0], z80_port_addr[row][p]},
                              1'b0, 1'b1, rgn_prog_rom, z80_port_t'(p));
                end
            end
            add_entry(1'b1, codes[c], 1'b0, m68k_base[row][1], 1'b1, 1'b0, rgn_ram, port_p1);
            add_entry(1'b1, codes[c], 1'b1, {16'h0000, z80_port_addr[row][0]}, 1'b1, 1'b0,
                      rgn_prog_rom, port_p1);
        end
        for (int k = 0; k < 3; k++) begin
            // hellfire z80 reset address falls in no region of these maps
            add_entry(1'b1, codes[k], 1'b0, 24'h180008, 1'b0, 1'b0, rgn_reset_z80, port_p1);
        end
        add_entry(1'b1, 8'd7, 1'b0, 24'h000000, 1'b0, 1'b0, rgn_prog_rom, port_p1);
        add_entry(1'b1, 8'd7, 1'b0, 24'h080000, 1'b0, 1'b0, rgn_ram, port_p1);
        add_entry(1'b1, 8'd7, 1'b1, 24'h000000, 1'b0, 1'b0, rgn_prog_rom, port_p1);
    endtask

    task automatic check_region(input logic exp_hit, input m68k_region_t exp_rgn,
                                input logic [n_m68k_regions-1:0] got, inout logic ok);
        logic [n_m68k_regions-1:0] exp;
        exp = exp_hit ? (21'h1 << exp_rgn) : '0;
        if (got !== exp) begin
            $display("ERROR %0t m68k_cs expected %h got %h", $time, exp, got);
            ok = 1'b0;
        end
    endtask

    task automatic check_port(input logic exp_hit, input z80_port_t exp_port,
                              input logic [n_z80_ports-1:0] got, inout logic ok);
        logic [n_z80_ports-1:0] exp;
        exp = exp_hit ? (8'h1 << exp_port) : '0;
        if (got !== exp) begin
            $display("ERROR %0t z80_cs expected %h got %h", $time, exp, got);
            ok = 1'b0;
        end
    endtask

    task automatic check_scroll(input logic [scroll_y_width-1:0] exp,
                                input logic [scroll_y_width-1:0] got, inout logic ok);
        if (got !== exp) begin
            $display("ERROR %0t scroll_y_offset expected %h got %h", $time, exp, got);
            ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        entry_t e;
        logic ok;
        build_table();
        cycle_limit = table_q.size() * 4 + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.cfg) begin
                pcb = e.code;
                cfg_strobe = 1'b1;
                cpu_as_n = 1'b1;
                iorq_n = 1'b1;
                @(negedge clk);
                cfg_strobe = 1'b0;
            end
            cpu_a = e.is_z80 ? '0 : e.addr;
            z80_addr = e.is_z80 ? e.addr[15:0] : '0;
            cpu_as_n = e.is_z80 ? 1'b1 : e.strobe_n;
            iorq_n = e.is_z80 ? e.strobe_n : 1'b1;
            @(negedge clk);   // selects registered at the rising edge between
            ok = 1'b1;
            check_region(e.exp_hit && !e.is_z80, e.exp_rgn, m68k_seen, ok);
            check_port(e.exp_hit && e.is_z80, e.exp_port, z80_seen, ok);
            check_scroll(e.exp_scroll, scroll_y_offset, ok);
            if (!ok) fails++;
            $display("test %0d code %0d %s addr %h %s", i, e.code,
                     e.is_z80 ? "z80" : "m68k", e.addr, ok ? "ok" : "mismatch");
        end
        $display("%0d tests run, %0d failed", table_q.size(), fails);
        if (fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
board_pkg.sv
map_pkg.sv
board_config.sv
m68k_decoder.sv
z80_decoder.sv
cs_register.sv
toaplan_chip_select.sv
tb_chip_select.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the chip select testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_chip_select -f build.f -o sim_chip_select

./obj_dir/sim_chip_select | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
